//--- all.f
verilog/fwd_pkg.sv
verilog/reg_file.sv
verilog/forwarding.sv
verilog/pipe_reg.sv
verilog/exec_alu.sv
verilog/operand_fetch.sv
verilog/operand_path_top.sv
dv/operand_path_tb.sv

//--- Makefile
SIM := obj_dir/operand_path_sim

all: $(SIM)

$(SIM): all.f $(wildcard verilog/*.sv dv/*.sv)
	verilator --binary --timing --assert --top-module operand_path_tb -f all.f -o operand_path_sim

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

.PHONY: all run clean

//--- dv/operand_path_tb.sv
`timescale 1ns/1ps

module operand_path_tb;
    import fwd_pkg::*;

    localparam int NUM_INSTR      = 40;
    localparam int STALL_FROM     = 27;     // random stalls from this entry on
    localparam int TIMEOUT_CYCLES = 4 * NUM_INSTR + 50;

    typedef struct {
        alu_op_t                   op;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [REG_ADDR_WIDTH-1:0] rs1;
        logic [REG_ADDR_WIDTH-1:0] rs2;
        logic [XLEN-1:0]           imm;
        logic                      use_imm;
        logic                      wben;
        logic [XLEN-1:0]           exp;
    } instr_t;

    typedef struct packed {
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [XLEN-1:0]           data;
    } commit_t;

    logic                      clk;
    logic                      rst_n;
    logic                      stall_n;
    logic                      issue_wben;
    alu_op_t                   issue_op;
    logic [REG_ADDR_WIDTH-1:0] issue_rd;
    logic [REG_ADDR_WIDTH-1:0] issue_rs1;
    logic [REG_ADDR_WIDTH-1:0] issue_rs2;
    logic [XLEN-1:0]           issue_imm;
    logic                      issue_use_imm;
    logic                      commit_valid;
    logic [REG_ADDR_WIDTH-1:0] commit_rd;
    logic [XLEN-1:0]           commit_data;

    instr_t  prog [NUM_INSTR];
    commit_t pending [$];
    int      prog_len;
    int      seed;
    int      idx;
    int      commits;
    int      expected_total;
    int      cycles;

    operand_path_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0d ns: %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_rd(input string name, input logic [REG_ADDR_WIDTH-1:0] got,
                            input logic [REG_ADDR_WIDTH-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0d ns: %s got %0d expected %0d",
                                $time, name, got, exp));
        end
    endtask

    function automatic logic [XLEN-1:0] expected_result(input alu_op_t op,
                                                        input logic [XLEN-1:0] a,
                                                        input logic [XLEN-1:0] b);
        case (op)
            ALU_ADD:   return a + b;
            ALU_SUB:   return a - b;
            ALU_AND:   return a & b;
            ALU_OR:    return a | b;
            ALU_XOR:   return a ^ b;
            ALU_PASSB: return b;
            default:   return '0;
        endcase
    endfunction

    task automatic put_instr(input alu_op_t op, input logic [REG_ADDR_WIDTH-1:0] rd,
                             input logic [REG_ADDR_WIDTH-1:0] rs1,
                             input logic [REG_ADDR_WIDTH-1:0] rs2,
                             input logic [XLEN-1:0] imm, input logic use_imm,
                             input logic wben);
        prog[prog_len] = '{op, rd, rs1, rs2, imm, use_imm, wben, '0};
        prog_len++;
    endtask

    task automatic load_program();
        prog_len = 0;
        put_instr(ALU_PASSB, 5'd1,  5'd0,  5'd0,  32'h0000_0011, 1'b1, 1'b1);
        put_instr(ALU_PASSB, 5'd2,  5'd0,  5'd0,  32'h0000_0022, 1'b1, 1'b1);
        put_instr(ALU_PASSB, 5'd3,  5'd0,  5'd0,  32'h0f0f_00ff, 1'b1, 1'b1);
        put_instr(ALU_ADD,   5'd4,  5'd1,  5'd2,  32'h0000_0000, 1'b0, 1'b1); // distance 3 and 2
        put_instr(ALU_ADD,   5'd5,  5'd4,  5'd0,  32'h0000_0001, 1'b1, 1'b1); // back to back
        put_instr(ALU_ADD,   5'd5,  5'd5,  5'd0,  32'h0000_0001, 1'b1, 1'b1);
        put_instr(ALU_SUB,   5'd5,  5'd5,  5'd3,  32'h0000_0000, 1'b0, 1'b1);
        put_instr(ALU_XOR,   5'd6,  5'd5,  5'd4,  32'h0000_0000, 1'b0, 1'b1);
        put_instr(ALU_PASSB, 5'd7,  5'd0,  5'd0,  32'h0000_0100, 1'b1, 1'b1);
        put_instr(ALU_PASSB, 5'd7,  5'd0,  5'd0,  32'h0000_0200, 1'b1, 1'b1);
        put_instr(ALU_PASSB, 5'd7,  5'd0,  5'd0,  32'h0000_0300, 1'b1, 1'b1);
        put_instr(ALU_ADD,   5'd8,  5'd7,  5'd7,  32'h0000_0000, 1'b0, 1'b1); // youngest x7 wins
        put_instr(ALU_OR,    5'd9,  5'd8,  5'd6,  32'h0000_0000, 1'b0, 1'b1);
        put_instr(ALU_PASSB, 5'd9,  5'd0,  5'd0,  32'h0000_0bad, 1'b1, 1'b0); // no commit
        put_instr(ALU_AND,   5'd10, 5'd9,  5'd3,  32'h0000_0000, 1'b0, 1'b1);
        put_instr(ALU_PASSB, 5'd0,  5'd0,  5'd0,  32'h0000_dead, 1'b1, 1'b1); // write to x0
        put_instr(ALU_ADD,   5'd11, 5'd0,  5'd0,  32'h0000_0000, 1'b0, 1'b1);
        put_instr(ALU_OR,    5'd12, 5'd0,  5'd0,  32'h0000_0055, 1'b1, 1'b1);
        put_instr(ALU_PASSB, 5'd13, 5'd0,  5'd0,  32'h0000_0000, 1'b0, 1'b1);
        put_instr(ALU_SUB,   5'd14, 5'd12, 5'd1,  32'h0000_0000, 1'b0, 1'b1);
        put_instr(ALU_SUB,   5'd15, 5'd1,  5'd14, 32'h0000_0000, 1'b0, 1'b1); // wraps below zero
        put_instr(ALU_XOR,   5'd16, 5'd15, 5'd15, 32'h0000_0000, 1'b0, 1'b1);
        put_instr(ALU_AND,   5'd17, 5'd2,  5'd0,  32'hffff_fff0, 1'b1, 1'b1);
        put_instr(ALU_ADD,   5'd17, 5'd0,  5'd0,  32'h0000_0000, 1'b0, 1'b0);
        put_instr(ALU_ADD,   5'd18, 5'd0,  5'd0,  32'h0000_0000, 1'b0, 1'b0);
        put_instr(ALU_ADD,   5'd18, 5'd17, 5'd16, 32'h0000_0000, 1'b0, 1'b1); // held value
        put_instr(ALU_ADD,   5'd19, 5'd18, 5'd17, 32'h0000_0000, 1'b0, 1'b1);
        put_instr(ALU_PASSB, 5'd20, 5'd0,  5'd0,  32'h1234_5678, 1'b1, 1'b1);
        put_instr(ALU_ADD,   5'd21, 5'd20, 5'd0,  32'hedcb_a988, 1'b1, 1'b1);
        put_instr(ALU_OR,    5'd22, 5'd20, 5'd3,  32'h0000_0000, 1'b0, 1'b1);
        put_instr(ALU_XOR,   5'd23, 5'd22, 5'd21, 32'h0000_0000, 1'b0, 1'b1);
        put_instr(ALU_SUB,   5'd20, 5'd23, 5'd20, 32'h0000_0000, 1'b0, 1'b1);
        put_instr(ALU_AND,   5'd24, 5'd20, 5'd22, 32'h0000_0000, 1'b0, 1'b1);
        put_instr(ALU_PASSB, 5'd25, 5'd0,  5'd24, 32'h0000_0000, 1'b0, 1'b1);
        put_instr(ALU_ADD,   5'd25, 5'd25, 5'd25, 32'h0000_0000, 1'b0, 1'b1);
        put_instr(ALU_PASSB, 5'd26, 5'd0,  5'd0,  32'h0000_7777, 1'b1, 1'b0);
        put_instr(ALU_ADD,   5'd26, 5'd25, 5'd26, 32'h0000_0000, 1'b0, 1'b1);
        put_instr(ALU_SUB,   5'd27, 5'd26, 5'd0,  32'h0000_0001, 1'b1, 1'b1);
        put_instr(ALU_XOR,   5'd28, 5'd27, 5'd20, 32'h0000_0000, 1'b0, 1'b1);
        put_instr(ALU_OR,    5'd29, 5'd28, 5'd0,  32'h8000_0000, 1'b1, 1'b1);
    endtask

    // shadow register model, run once in program order
    task automatic fill_expected();
        logic [XLEN-1:0] regs [NUM_REGS];
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        for (int r = 0; r < NUM_REGS; r++) begin
            regs[r] = '0;
        end
        expected_total = 0;
        for (int i = 0; i < NUM_INSTR; i++) begin
            a = regs[prog[i].rs1];
            b = prog[i].use_imm ? prog[i].imm : regs[prog[i].rs2];
            prog[i].exp = expected_result(prog[i].op, a, b);
            if (prog[i].wben) begin
                pending.push_back({prog[i].rd, prog[i].exp});
                expected_total++;
                if (prog[i].rd != '0) begin
                    regs[prog[i].rd] = prog[i].exp;     // x0 stays zero
                end
            end
        end
    endtask

    // runs at a falling edge: pick stall, drive the slot, then look at the commit port
    task automatic apply_cycle(input int slot);
        commit_t c;
        stall_n = (slot < STALL_FROM) || (($random(seed) & 3) != 0);
        if (slot < NUM_INSTR) begin
            issue_wben    = prog[slot].wben;
            issue_op      = prog[slot].op;
            issue_rd      = prog[slot].rd;
            issue_rs1     = prog[slot].rs1;
            issue_rs2     = prog[slot].rs2;
            issue_imm     = prog[slot].imm;
            issue_use_imm = prog[slot].use_imm;
        end else begin
            issue_wben = 1'b0;      // bubbles while the pipe drains
        end
        if (commit_valid && stall_n) begin
            if (pending.size() == 0) begin
                abort_run("commit seen with no instruction outstanding");
            end else begin
                c = pending.pop_front();
                check_rd("commit_rd", commit_rd, c.rd);
                check_data("commit_data", commit_data, c.data);
                commits++;
            end
        end
    endtask

    initial begin
        seed          = 82;
        rst_n         = 1'b0;
        stall_n       = 1'b1;
        issue_wben    = 1'b0;
        issue_op      = ALU_ADD;
        issue_rd      = '0;
        issue_rs1     = '0;
        issue_rs2     = '0;
        issue_imm     = '0;
        issue_use_imm = 1'b0;
        idx           = 0;
        commits       = 0;
        load_program();
        fill_expected();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // six trailing bubble slots drain the pipe and catch extra commits
        while (idx < NUM_INSTR + 6) begin
            apply_cycle(idx);
            @(posedge clk);
            if (stall_n) begin
                idx++;
            end
            @(negedge clk);
        end
        if (pending.size() != 0 || commits != expected_total) begin
            abort_run($sformatf("only %0d of %0d commits were seen", commits, expected_total));
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        abort_run($sformatf("timeout after %0d cycles", TIMEOUT_CYCLES));
    end

endmodule

//--- verilog/operand_path_top.sv
`timescale 1ns/1ps

module operand_path_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               stall_n,
    input  logic                               issue_wben,
    input  fwd_pkg::alu_op_t                   issue_op,
    input  logic [fwd_pkg::REG_ADDR_WIDTH-1:0] issue_rd,
    input  logic [fwd_pkg::REG_ADDR_WIDTH-1:0] issue_rs1,
    input  logic [fwd_pkg::REG_ADDR_WIDTH-1:0] issue_rs2,
    input  logic [fwd_pkg::XLEN-1:0]           issue_imm,
    input  logic                               issue_use_imm,
    output logic                               commit_valid,
    output logic [fwd_pkg::REG_ADDR_WIDTH-1:0] commit_rd,
    output logic [fwd_pkg::XLEN-1:0]           commit_data
);
    import fwd_pkg::*;

    ex_stage_t  ex_next;
    ex_stage_t  ex_q;
    res_stage_t alu_res;
    res_stage_t ls_q;
    res_stage_t wb_q;

    // EX source is the ALU output of the instruction one ahead of decode,
    // LS source is the memory-slot register, which also feeds the write port
    operand_fetch u_operand_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall_n       (stall_n),
        .issue_wben    (issue_wben),
        .issue_op      (issue_op),
        .issue_rd      (issue_rd),
        .issue_rs1     (issue_rs1),
        .issue_rs2     (issue_rs2),
        .issue_imm     (issue_imm),
        .issue_use_imm (issue_use_imm),
        .ex_wben       (alu_res.wben),
        .ex_rd         (alu_res.rd),
        .ex_data       (alu_res.data),
        .ls_wben       (ls_q.wben),
        .ls_rd         (ls_q.rd),
        .ls_data       (ls_q.data),
        .fetch_out     (ex_next)
    );

    pipe_reg #(.payload_t(ex_stage_t)) u_ex_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (stall_n),
        .d     (ex_next),
        .q     (ex_q)
    );

    exec_alu u_exec_alu (
        .ex_in   (ex_q),
        .res_out (alu_res)
    );

    pipe_reg #(.payload_t(res_stage_t)) u_ls_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (stall_n),
        .d     (alu_res),
        .q     (ls_q)
    );

    pipe_reg #(.payload_t(res_stage_t)) u_wb_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (stall_n),
        .d     (ls_q),
        .q     (wb_q)
    );

    assign commit_valid = wb_q.wben;    // repeats while stalled
    assign commit_rd    = wb_q.rd;
    assign commit_data  = wb_q.data;

endmodule

//--- verilog/operand_fetch.sv
`timescale 1ns/1ps

module operand_fetch (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               stall_n,
    input  logic                               issue_wben,
    input  fwd_pkg::alu_op_t                   issue_op,
    input  logic [fwd_pkg::REG_ADDR_WIDTH-1:0] issue_rd,
    input  logic [fwd_pkg::REG_ADDR_WIDTH-1:0] issue_rs1,
    input  logic [fwd_pkg::REG_ADDR_WIDTH-1:0] issue_rs2,
    input  logic [fwd_pkg::XLEN-1:0]           issue_imm,
    input  logic                               issue_use_imm,
    input  logic                               ex_wben,
    input  logic [fwd_pkg::REG_ADDR_WIDTH-1:0] ex_rd,
    input  logic [fwd_pkg::XLEN-1:0]           ex_data,
    input  logic                               ls_wben,
    input  logic [fwd_pkg::REG_ADDR_WIDTH-1:0] ls_rd,
    input  logic [fwd_pkg::XLEN-1:0]           ls_data,
    output fwd_pkg::ex_stage_t                 fetch_out
);
    import fwd_pkg::*;

    logic                      dec_wben;
    alu_op_t                   dec_op;
    logic [REG_ADDR_WIDTH-1:0] dec_rd;
    logic [REG_ADDR_WIDTH-1:0] dec_rs1;
    logic [REG_ADDR_WIDTH-1:0] dec_rs2;
    logic [XLEN-1:0]           dec_imm;
    logic                      dec_use_imm;
    logic [XLEN-1:0]           rf_rs1;
    logic [XLEN-1:0]           rf_rs2;
    logic [XLEN-1:0]           held_data;
    logic [XLEN-1:0]           rs1_val;
    logic [XLEN-1:0]           rs2_val;
    fwd_sel_t                  rs1_sel;
    fwd_sel_t                  rs2_sel;

    // decode register, the issue sampling point
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_wben    <= 1'b0;
            dec_op      <= ALU_ADD;
            dec_rd      <= '0;
            dec_rs1     <= '0;
            dec_rs2     <= '0;
            dec_imm     <= '0;
            dec_use_imm <= 1'b0;
        end else if (stall_n) begin
            dec_wben    <= issue_wben;
            dec_op      <= issue_op;
            dec_rd      <= issue_rd;
            dec_rs1     <= issue_rs1;
            dec_rs2     <= issue_rs2;
            dec_imm     <= issue_imm;
            dec_use_imm <= issue_use_imm;
        end
    end

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_idx  (dec_rs1),
        .rs2_idx  (dec_rs2),
        .wr_en    (ls_wben),
        .wr_idx   (ls_rd),
        .wr_data  (ls_data),
        .stall_n  (stall_n),
        .rs1_data (rf_rs1),
        .rs2_data (rf_rs2)
    );

    forwarding u_forwarding (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1_idx   (dec_rs1),
        .rs2_idx   (dec_rs2),
        .ex_rd     (ex_rd),
        .ls_rd     (ls_rd),
        .ex_wben   (ex_wben),
        .ls_wben   (ls_wben),
        .wb_data_i (ls_data),
        .stall_n   (stall_n),
        .rs1_sel   (rs1_sel),
        .rs2_sel   (rs2_sel),
        .wb_data_o (held_data)
    );

    function automatic logic [XLEN-1:0] pick(input fwd_sel_t sel, input logic [XLEN-1:0] rf,
                                             input logic [XLEN-1:0] held);
        case (sel)
            SEL_EX:  return ex_data;
            SEL_LS:  return ls_data;
            SEL_WB:  return held;
            default: return rf;
        endcase
    endfunction

    assign rs1_val = pick(rs1_sel, rf_rs1, held_data);
    assign rs2_val = pick(rs2_sel, rf_rs2, held_data);

    always_comb begin
        fetch_out.wben = dec_wben;
        fetch_out.rd   = dec_rd;
        fetch_out.op   = dec_op;
        fetch_out.a    = rs1_val;
        fetch_out.b    = dec_use_imm ? dec_imm : rs2_val;   // immediate replaces rs2
    end

endmodule

//--- verilog/exec_alu.sv
`timescale 1ns/1ps

module exec_alu (
    input  fwd_pkg::ex_stage_t  ex_in,
    output fwd_pkg::res_stage_t res_out
);
    import fwd_pkg::*;

    logic [XLEN-1:0] result;

    always_comb begin
        case (ex_in.op)
            ALU_ADD:   result = ex_in.a + ex_in.b;     // wraps
            ALU_SUB:   result = ex_in.a - ex_in.b;
            ALU_AND:   result = ex_in.a & ex_in.b;
            ALU_OR:    result = ex_in.a | ex_in.b;
            ALU_XOR:   result = ex_in.a ^ ex_in.b;
            ALU_PASSB: result = ex_in.b;
            default:   result = '0;
        endcase
    end

    always_comb begin
        res_out.wben = ex_in.wben;
        res_out.rd   = ex_in.rd;
        res_out.data = result;
    end

endmodule

//--- verilog/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;        // clears wben as well
        end else if (en) begin
            q <= d;
        end
    end

    a_hold_when_disabled: assert property (@(posedge clk) disable iff (!rst_n)
        !en |=> $stable(q));

endmodule

//--- verilog/forwarding.sv
`timescale 1ns/1ps

module forwarding (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [fwd_pkg::REG_ADDR_WIDTH-1:0] rs1_idx,
    input  logic [fwd_pkg::REG_ADDR_WIDTH-1:0] rs2_idx,
    input  logic [fwd_pkg::REG_ADDR_WIDTH-1:0] ex_rd,
    input  logic [fwd_pkg::REG_ADDR_WIDTH-1:0] ls_rd,
    input  logic                               ex_wben,
    input  logic                               ls_wben,
    input  logic [fwd_pkg::XLEN-1:0]           wb_data_i,
    input  logic                               stall_n,
    output fwd_pkg::fwd_sel_t                  rs1_sel,
    output fwd_pkg::fwd_sel_t                  rs2_sel,
    output logic [fwd_pkg::XLEN-1:0]           wb_data_o
);
    import fwd_pkg::*;

    logic                      held_valid;
    logic [REG_ADDR_WIDTH-1:0] held_idx;
    logic [XLEN-1:0]           held_data;
    logic                      rs1_ex_fw;
    logic                      rs1_ls_fw;
    logic                      rs1_wb_fw;
    logic                      rs2_ex_fw;
    logic                      rs2_ls_fw;
    logic                      rs2_wb_fw;

    // copy of the value going into the register file staging slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
            held_idx   <= '0;
        end else if (ls_wben && stall_n) begin
            held_valid <= 1'b1;
            held_idx   <= ls_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (ls_wben && stall_n) begin
            held_data <= wb_data_i;
        end
    end

    assign wb_data_o = held_data;

    function automatic fwd_sel_t resolve(input logic ex_hit, input logic ls_hit,
                                         input logic wb_hit);
        if (ex_hit) begin
            return SEL_EX;      // youngest producer first
        end else if (ls_hit) begin
            return SEL_LS;
        end else if (wb_hit) begin
            return SEL_WB;
        end
        return SEL_RF;
    endfunction

    assign rs1_ex_fw = ex_wben && (ex_rd == rs1_idx) && (|ex_rd);
    assign rs1_ls_fw = ls_wben && (ls_rd == rs1_idx) && (|ls_rd);
    assign rs1_wb_fw = held_valid && (held_idx == rs1_idx) && (|held_idx);

    assign rs2_ex_fw = ex_wben && (ex_rd == rs2_idx) && (|ex_rd);
    assign rs2_ls_fw = ls_wben && (ls_rd == rs2_idx) && (|ls_rd);
    assign rs2_wb_fw = held_valid && (held_idx == rs2_idx) && (|held_idx);

    assign rs1_sel = resolve(rs1_ex_fw, rs1_ls_fw, rs1_wb_fw);
    assign rs2_sel = resolve(rs2_ex_fw, rs2_ls_fw, rs2_wb_fw);

    a_rs1_x0_rf: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1_idx == '0) |-> (rs1_sel == SEL_RF));
    a_rs2_x0_rf: assert property (@(posedge clk) disable iff (!rst_n)
        (rs2_idx == '0) |-> (rs2_sel == SEL_RF));

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [fwd_pkg::REG_ADDR_WIDTH-1:0] rs1_idx,
    input  logic [fwd_pkg::REG_ADDR_WIDTH-1:0] rs2_idx,
    input  logic                               wr_en,
    input  logic [fwd_pkg::REG_ADDR_WIDTH-1:0] wr_idx,
    input  logic [fwd_pkg::XLEN-1:0]           wr_data,
    input  logic                               stall_n,
    output logic [fwd_pkg::XLEN-1:0]           rs1_data,
    output logic [fwd_pkg::XLEN-1:0]           rs2_data
);
    import fwd_pkg::*;

    logic [XLEN-1:0]           mem [NUM_REGS];
    logic                      stage_en;
    logic [REG_ADDR_WIDTH-1:0] stage_idx;
    logic [XLEN-1:0]           stage_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_en <= 1'b0;
        end else if (stall_n) begin
            stage_en <= wr_en && (wr_idx != '0);   // x0 writes dropped here
        end
    end

    always_ff @(posedge clk) begin
        if (stall_n) begin
            stage_idx  <= wr_idx;
            stage_data <= wr_data;
        end
    end

    // staged write lands one edge after capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                mem[i] <= '0;
            end
        end else if (stall_n && stage_en) begin
            mem[stage_idx] <= stage_data;
        end
    end

    assign rs1_data = mem[rs1_idx];     // entry 0 never written
    assign rs2_data = mem[rs2_idx];

    a_x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
        ((rs1_idx == '0) |-> (rs1_data == '0)) and ((rs2_idx == '0) |-> (rs2_data == '0)));

endmodule

//--- verilog/fwd_pkg.sv
package fwd_pkg;

    localparam int XLEN           = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int NUM_REGS       = 32;

    // operand source, in falling priority EX > LS > WB > RF
    typedef enum logic [1:0] {
        SEL_RF = 2'd0,      // register file array
        SEL_EX = 2'd1,      // one instruction older
        SEL_LS = 2'd2,      // two older
        SEL_WB = 2'd3       // held last written value
    } fwd_sel_t;

    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_AND   = 3'd2,
        ALU_OR    = 3'd3,
        ALU_XOR   = 3'd4,
        ALU_PASSB = 3'd5
    } alu_op_t;

    // 73 bits
    typedef struct packed {
        logic                      wben;    // doubles as stage valid
        logic [REG_ADDR_WIDTH-1:0] rd;
        alu_op_t                   op;
        logic [XLEN-1:0]           a;
        logic [XLEN-1:0]           b;
    } ex_stage_t;

    // 38 bits
    typedef struct packed {
        logic                      wben;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [XLEN-1:0]           data;
    } res_stage_t;

endpackage
